// ==== snow64_sign_extend.svh ====
`ifndef SNOW64_SIGN_EXTEND_SVH
`define SNOW64_SIGN_EXTEND_SVH

// value must be a plain name or field select
`define SNOW64_SIGN_EXTEND(to_width, from_width, value) \
	{{((to_width) - (from_width)){value[(from_width) - 1]}}, value}

`endif

// ==== snow64_isa_pkg.sv ====
package snow64_isa_pkg;

	// word and datapath widths
	localparam int WIDTH_INSTR = 32;
	localparam int WIDTH_ADDR = 64;
	localparam int WIDTH_DATA = 32;
	localparam int NUM_REGS = 16;

	// immediate field widths per format
	localparam int WIDTH_SIMM12 = 12;
	localparam int WIDTH_SIMM16 = 16;
	localparam int WIDTH_SIMM20 = 20;

	typedef logic [3:0] reg_index_t;
	typedef logic [3:0] oper_t;
	typedef logic [2:0] group_t;

	// instruction groups with a real format
	localparam group_t IOG0_GROUP = 3'd0;
	localparam group_t IOG1_GROUP = 3'd1;
	localparam group_t IOG2_GROUP = 3'd2;
	localparam group_t IOG3_GROUP = 3'd3;
	localparam group_t IOG4_GROUP = 3'd4;

	// the only legal opers with bit 3 set in groups 2..4
	localparam oper_t LDF16_OPER = 4'd8;
	localparam oper_t STF16_OPER = 4'd8;
	localparam oper_t OUT_OPER = 4'd8;

	// reserved opers of group 0
	localparam oper_t BAD0_IOG0 = 4'd13;
	localparam oper_t BAD1_IOG0 = 4'd14;
	localparam oper_t BAD2_IOG0 = 4'd15;

	// three regs plus simm12
	typedef struct packed
	{
		group_t group;
		logic op_type;
		reg_index_t ra_index;
		reg_index_t rb_index;
		reg_index_t rc_index;
		oper_t oper;
		logic [WIDTH_SIMM12-1:0] simm12;
	} iog0_instr_t;

	// one reg plus simm20
	typedef struct packed
	{
		group_t group;
		logic op_type;
		reg_index_t ra_index;
		oper_t oper;
		logic [WIDTH_SIMM20-1:0] simm20;
	} iog1_instr_t;

	// loads
	typedef iog0_instr_t iog2_instr_t;

	// stores
	typedef iog0_instr_t iog3_instr_t;

	// port i/o, two regs plus simm16
	typedef struct packed
	{
		group_t group;
		logic op_type;
		reg_index_t ra_index;
		reg_index_t rb_index;
		oper_t oper;
		logic [WIDTH_SIMM16-1:0] simm16;
	} iog4_instr_t;

	// one word, five ways to read it
	typedef union packed
	{
		iog0_instr_t iog0;
		iog1_instr_t iog1;
		iog2_instr_t iog2;
		iog3_instr_t iog3;
		iog4_instr_t iog4;
	} instr_word_u;

	// what leaves the front end per instruction
	typedef struct packed
	{
		group_t group;
		logic op_type;
		oper_t oper;
		reg_index_t ra_index;
		reg_index_t rb_index;
		reg_index_t rc_index;
		logic nop;
		logic [WIDTH_ADDR-1:0] signext_imm;
		logic [WIDTH_DATA-1:0] ra_val;
		logic [WIDTH_DATA-1:0] rb_val;
		logic [WIDTH_DATA-1:0] rc_val;
	} issue_bundle_t;

endpackage

// ==== snow64_bus_pkg.sv ====
package snow64_bus_pkg;

	// axi4-lite widths
	localparam int WIDTH_AXIL_ADDR = 12;
	localparam int WIDTH_AXIL_DATA = 32;
	localparam int WIDTH_AXIL_STRB = WIDTH_AXIL_DATA / 8;

	typedef struct packed
	{
		logic [WIDTH_AXIL_ADDR-1:0] addr;
	} axil_aw_t;

	typedef struct packed
	{
		logic [WIDTH_AXIL_DATA-1:0] data;
		logic [WIDTH_AXIL_STRB-1:0] strb;
	} axil_w_t;

	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'd0;
	localparam axil_resp_t RESP_SLVERR = 2'd2;

	// address map
	localparam logic [WIDTH_AXIL_ADDR-1:0] ADDR_INSTR = 12'h000;
	// register i sits at base + 4*i
	localparam logic [WIDTH_AXIL_ADDR-1:0] ADDR_REG_BASE = 12'h040;

	typedef enum logic
	{
		ITEM_INSTR = 1'b0,
		ITEM_REG_WRITE = 1'b1
	} item_kind_t;

	// one accepted bus write on its way down the pipe
	typedef struct packed
	{
		item_kind_t kind;
		snow64_isa_pkg::reg_index_t reg_index;
		logic [snow64_isa_pkg::WIDTH_INSTR-1:0] word;
	} front_item_t;

endpackage

// ==== snow64_instr_ingress.sv ====
`timescale 1ns/1ps

module snow64_instr_ingress
	(input logic clk,
	input logic rst,
	input logic awvalid,
	input logic wvalid,
	input logic bready,
	input snow64_bus_pkg::axil_aw_t aw,
	input snow64_bus_pkg::axil_w_t w,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output snow64_bus_pkg::axil_resp_t bresp,
	output logic item_valid,
	output snow64_bus_pkg::front_item_t item,
	input logic item_ready);

	logic slot_free;
	logic accept;
	logic addr_is_instr;
	logic addr_is_reg;
	logic full_strb;
	logic write_ok;
	logic [snow64_bus_pkg::WIDTH_AXIL_ADDR-1:0] reg_offset;
	snow64_bus_pkg::front_item_t next_item;

	// output slot can take a new item this cycle
	assign slot_free = !item_valid || item_ready;

	// aw and w are taken together, one write in flight
	assign accept = awvalid && wvalid && !bvalid && slot_free;
	assign awready = accept;
	assign wready = accept;

	// address decode
	assign reg_offset = aw.addr - snow64_bus_pkg::ADDR_REG_BASE;
	assign addr_is_instr = (aw.addr == snow64_bus_pkg::ADDR_INSTR);
	assign addr_is_reg = (aw.addr >= snow64_bus_pkg::ADDR_REG_BASE)
		&& (reg_offset[snow64_bus_pkg::WIDTH_AXIL_ADDR-1:2]
		< 10'(snow64_isa_pkg::NUM_REGS))
		&& (reg_offset[1:0] == 2'b00);
	assign full_strb = &w.strb;
	assign write_ok = (addr_is_instr || addr_is_reg) && full_strb;

	always_comb
	begin
		next_item.kind = addr_is_instr ? snow64_bus_pkg::ITEM_INSTR
			: snow64_bus_pkg::ITEM_REG_WRITE;
		next_item.reg_index = reg_offset[5:2];
		next_item.word = w.data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bvalid <= 1'b0;
			item_valid <= 1'b0;
		end
		else
		begin
			if (accept)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			// bad writes get a response but never an item
			if (accept && write_ok)
				item_valid <= 1'b1;
			else if (item_ready)
				item_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			bresp <= write_ok ? snow64_bus_pkg::RESP_OKAY : snow64_bus_pkg::RESP_SLVERR;
		if (accept && write_ok)
			item <= next_item;
	end

endmodule

// ==== snow64_instr_decoder.sv ====
`timescale 1ns/1ps

`include "snow64_sign_extend.svh"

module snow64_instr_decoder
	(input logic clk,
	input logic rst,
	input logic in_valid,
	input snow64_bus_pkg::front_item_t in_item,
	output logic in_ready,
	output logic out_valid,
	output snow64_bus_pkg::item_kind_t out_kind,
	output snow64_isa_pkg::reg_index_t out_reg_index,
	output logic [snow64_isa_pkg::WIDTH_INSTR-1:0] out_word,
	output snow64_isa_pkg::issue_bundle_t out_bundle,
	input logic out_ready);

	logic accept;
	snow64_isa_pkg::instr_word_u instr;
	snow64_isa_pkg::issue_bundle_t dec;

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	assign instr = in_item.word;

	always_comb
	begin
		// operand values stay zero here, fetch fills them
		dec = '0;

		// head and register indices always read through the group 0 view
		dec.group = instr.iog0.group;
		dec.op_type = instr.iog0.op_type;
		dec.ra_index = instr.iog0.ra_index;
		dec.rb_index = instr.iog0.rb_index;
		dec.rc_index = instr.iog0.rc_index;

		case (instr.iog0.group)
		snow64_isa_pkg::IOG0_GROUP:
		begin
			dec.oper = instr.iog0.oper;
			dec.nop = (instr.iog0.oper == snow64_isa_pkg::BAD0_IOG0)
				|| (instr.iog0.oper == snow64_isa_pkg::BAD1_IOG0)
				|| (instr.iog0.oper == snow64_isa_pkg::BAD2_IOG0);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(snow64_isa_pkg::WIDTH_ADDR,
				snow64_isa_pkg::WIDTH_SIMM12, instr.iog0.simm12);
		end

		snow64_isa_pkg::IOG1_GROUP:
		begin
			dec.oper = instr.iog1.oper;
			// top quarter of the group 1 opers is unused
			dec.nop = instr.iog1.oper[3] && instr.iog1.oper[2];
			dec.signext_imm = `SNOW64_SIGN_EXTEND(snow64_isa_pkg::WIDTH_ADDR,
				snow64_isa_pkg::WIDTH_SIMM20, instr.iog1.simm20);
		end

		snow64_isa_pkg::IOG2_GROUP:
		begin
			dec.oper = instr.iog2.oper;
			dec.nop = instr.iog2.oper[3]
				&& (instr.iog2.oper != snow64_isa_pkg::LDF16_OPER);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(snow64_isa_pkg::WIDTH_ADDR,
				snow64_isa_pkg::WIDTH_SIMM12, instr.iog2.simm12);
		end

		snow64_isa_pkg::IOG3_GROUP:
		begin
			dec.oper = instr.iog3.oper;
			dec.nop = instr.iog3.oper[3]
				&& (instr.iog3.oper != snow64_isa_pkg::STF16_OPER);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(snow64_isa_pkg::WIDTH_ADDR,
				snow64_isa_pkg::WIDTH_SIMM12, instr.iog3.simm12);
		end

		snow64_isa_pkg::IOG4_GROUP:
		begin
			dec.oper = instr.iog4.oper;
			dec.nop = instr.iog4.oper[3]
				&& (instr.iog4.oper != snow64_isa_pkg::OUT_OPER);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(snow64_isa_pkg::WIDTH_ADDR,
				snow64_isa_pkg::WIDTH_SIMM16, instr.iog4.simm16);
		end

		// groups 5..7 have no format
		default:
		begin
			dec.oper = '0;
			dec.nop = 1'b1;
			dec.signext_imm = '0;
		end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	// register writes ride along with kind, index and word
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_kind <= in_item.kind;
			out_reg_index <= in_item.reg_index;
			out_word <= in_item.word;
			out_bundle <= dec;
		end
	end

endmodule

// ==== snow64_operand_fetch.sv ====
`timescale 1ns/1ps

module snow64_operand_fetch
	(input logic clk,
	input logic rst,
	input logic in_valid,
	input snow64_bus_pkg::item_kind_t in_kind,
	input snow64_isa_pkg::reg_index_t in_reg_index,
	input logic [snow64_isa_pkg::WIDTH_INSTR-1:0] in_word,
	input snow64_isa_pkg::issue_bundle_t in_bundle,
	output logic in_ready,
	output logic out_valid,
	output snow64_isa_pkg::issue_bundle_t out_bundle,
	input logic out_ready);

	logic accept;
	logic is_instr;
	logic [snow64_isa_pkg::WIDTH_DATA-1:0] regs [snow64_isa_pkg::NUM_REGS];
	snow64_isa_pkg::issue_bundle_t fetched;

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;
	assign is_instr = (in_kind == snow64_bus_pkg::ITEM_INSTR);

	// register file
	// writes arrive in bus order, so any earlier write
	// has already landed when an instruction reads here
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < snow64_isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (accept && !is_instr)
		begin
			regs[in_reg_index] <= in_word;
		end
	end

	// operand read
	always_comb
	begin
		fetched = in_bundle;
		fetched.ra_val = regs[in_bundle.ra_index];
		fetched.rb_val = regs[in_bundle.rb_index];
		fetched.rc_val = regs[in_bundle.rc_index];
	end

	// register writes are swallowed here, only instructions go out
	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid && is_instr;
	end

	always_ff @(posedge clk)
	begin
		if (accept && is_instr)
			out_bundle <= fetched;
	end

endmodule

// ==== snow64_decode_front.sv ====
`timescale 1ns/1ps

module snow64_decode_front
	(input logic clk,
	input logic rst,
	input logic awvalid,
	input logic wvalid,
	input logic bready,
	input snow64_bus_pkg::axil_aw_t aw,
	input snow64_bus_pkg::axil_w_t w,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output snow64_bus_pkg::axil_resp_t bresp,
	output logic out_valid,
	output snow64_isa_pkg::issue_bundle_t out_bundle,
	input logic out_ready);

	// ingress to decoder
	logic item_valid;
	logic item_ready;
	snow64_bus_pkg::front_item_t item;

	// decoder to fetch
	logic dec_valid;
	logic dec_ready;
	snow64_bus_pkg::item_kind_t dec_kind;
	snow64_isa_pkg::reg_index_t dec_reg_index;
	logic [snow64_isa_pkg::WIDTH_INSTR-1:0] dec_word;
	snow64_isa_pkg::issue_bundle_t dec_bundle;

	snow64_instr_ingress u_ingress
		(.clk(clk), .rst(rst),
		.awvalid(awvalid), .wvalid(wvalid), .bready(bready),
		.aw(aw), .w(w),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
		.item_valid(item_valid), .item(item), .item_ready(item_ready));

	snow64_instr_decoder u_decoder
		(.clk(clk), .rst(rst),
		.in_valid(item_valid), .in_item(item), .in_ready(item_ready),
		.out_valid(dec_valid), .out_kind(dec_kind), .out_reg_index(dec_reg_index),
		.out_word(dec_word), .out_bundle(dec_bundle), .out_ready(dec_ready));

	snow64_operand_fetch u_fetch
		(.clk(clk), .rst(rst),
		.in_valid(dec_valid), .in_kind(dec_kind), .in_reg_index(dec_reg_index),
		.in_word(dec_word), .in_bundle(dec_bundle), .in_ready(dec_ready),
		.out_valid(out_valid), .out_bundle(out_bundle), .out_ready(out_ready));

endmodule

// ==== snow64_decode_front_tb.sv ====
`timescale 1ns/1ps

module snow64_decode_front_tb;

	// 13 + 22 + 8 + 3 + 200 + 1 bus writes over all tests
	localparam int TOTAL_WRITES = 247;
	localparam int CYCLE_LIMIT = 20 * TOTAL_WRITES + 200;

	logic clk;
	logic rst;
	logic awvalid;
	logic wvalid;
	logic bready;
	snow64_bus_pkg::axil_aw_t aw;
	snow64_bus_pkg::axil_w_t w;
	logic awready;
	logic wready;
	logic bvalid;
	snow64_bus_pkg::axil_resp_t bresp;
	logic out_valid;
	snow64_isa_pkg::issue_bundle_t out_bundle;
	logic out_ready;

	integer seed;
	int cycle_count = 0;
	int last_hs_cycle;
	int mismatch_errors;
	int other_errors;
	logic random_ready;
	logic [31:0] ready_rnd;
	logic [31:0] stim_rnd;
	logic [31:0] stim_data;
	string test_name;
	logic [31:0] model_regs [16];
	snow64_isa_pkg::issue_bundle_t expect_q [$];
	snow64_bus_pkg::axil_resp_t resp_q [$];
	snow64_isa_pkg::issue_bundle_t exp_bundle;
	snow64_bus_pkg::axil_resp_t exp_resp;

	snow64_decode_front uut
		(.clk(clk), .rst(rst),
		.awvalid(awvalid), .wvalid(wvalid), .bready(bready),
		.aw(aw), .w(w),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
		.out_valid(out_valid), .out_bundle(out_bundle), .out_ready(out_ready));

	always #20 clk = ~clk;

	// expected bundle straight from the group formats
	function automatic snow64_isa_pkg::issue_bundle_t predict_bundle(input logic [31:0] word,
		input logic [31:0] regs [16]);
		snow64_isa_pkg::issue_bundle_t b;
		b = '0;
		b.group = word[31:29];
		b.op_type = word[28];
		b.ra_index = word[27:24];
		b.rb_index = word[23:20];
		b.rc_index = word[19:16];
		case (word[31:29])
		3'd0:
		begin
			b.oper = word[15:12];
			b.nop = (word[15:12] >= 4'd13);
			b.signext_imm = {{52{word[11]}}, word[11:0]};
		end
		3'd1:
		begin
			b.oper = word[23:20];
			b.nop = word[23] && word[22];
			b.signext_imm = {{44{word[19]}}, word[19:0]};
		end
		3'd2, 3'd3:
		begin
			b.oper = word[15:12];
			b.nop = word[15] && (word[15:12] != 4'd8);
			b.signext_imm = {{52{word[11]}}, word[11:0]};
		end
		3'd4:
		begin
			b.oper = word[19:16];
			b.nop = word[19] && (word[19:16] != 4'd8);
			b.signext_imm = {{48{word[15]}}, word[15:0]};
		end
		default:
			b.nop = 1'b1;
		endcase
		b.ra_val = regs[b.ra_index];
		b.rb_val = regs[b.rb_index];
		b.rc_val = regs[b.rc_index];
		return b;
	endfunction

	task automatic check_bundle(input snow64_isa_pkg::issue_bundle_t exp,
		input snow64_isa_pkg::issue_bundle_t act);
		if (exp !== act)
		begin
			mismatch_errors++;
			$display("mismatch %s bundle: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic check_resp(input snow64_bus_pkg::axil_resp_t exp,
		input snow64_bus_pkg::axil_resp_t act);
		if (exp !== act)
		begin
			mismatch_errors++;
			$display("mismatch %s bresp: expected %0d, actual %0d", test_name, exp, act);
		end
	endtask

	task automatic check_flag(input string label, input logic exp, input logic act);
		if (exp !== act)
		begin
			mismatch_errors++;
			$display("mismatch %s %s: expected %b, actual %b", test_name, label, exp, act);
		end
	endtask

	task automatic check_latency(input int exp, input int act);
		if (exp != act)
		begin
			mismatch_errors++;
			$display("mismatch %s latency: expected %0d, actual %0d", test_name, exp, act);
		end
	endtask

	// bus side of the model, applied at the handshake
	task automatic model_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic full;
		logic is_reg;
		full = (strb == 4'hf);
		is_reg = (addr >= snow64_bus_pkg::ADDR_REG_BASE) && (addr <= 12'h07c)
			&& (addr[1:0] == 2'b00);
		if (full && addr == snow64_bus_pkg::ADDR_INSTR)
		begin
			expect_q.push_back(predict_bundle(data, model_regs));
			resp_q.push_back(snow64_bus_pkg::RESP_OKAY);
		end
		else if (full && is_reg)
		begin
			model_regs[addr[5:2]] = data;
			resp_q.push_back(snow64_bus_pkg::RESP_OKAY);
		end
		else
			resp_q.push_back(snow64_bus_pkg::RESP_SLVERR);
	endtask

	// called and returns 2 ns after a rising edge
	task automatic write_bus(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		aw.addr = addr;
		w.data = data;
		w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do
			@(posedge clk);
		while (!awready);
		last_hs_cycle = cycle_count;
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic issue_instr(input logic [31:0] word);
		write_bus(snow64_bus_pkg::ADDR_INSTR, word, 4'hf);
	endtask

	// let the pipe empty, bounded so a lost bundle cannot stall here
	task automatic drain();
		int waited;
		waited = 0;
		while ((expect_q.size() != 0 || resp_q.size() != 0) && waited < 60)
		begin
			@(posedge clk);
			waited++;
		end
		@(posedge clk);
		#2;
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles in %s, errors: %0d mismatches, %0d other",
				cycle_count, test_name, mismatch_errors, other_errors);
			$display("Regression failed");
			$finish;
		end
	end

	// sink and response readiness
	always @(posedge clk)
	begin
		#2;
		if (random_ready)
		begin
			ready_rnd = $random(seed);
			out_ready = ready_rnd[0];
			bready = ready_rnd[1];
		end
		else
		begin
			out_ready = 1'b1;
			bready = 1'b1;
		end
	end

	// scoreboard
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (awvalid && awready)
			begin
				check_flag("wready", 1'b1, wready);
				model_write(aw.addr, w.data, w.strb);
			end
			// no data handshake without a data beat
			if (!wvalid)
				check_flag("wready", 1'b0, wready);
			if (bvalid && bready)
			begin
				if (resp_q.size() == 0)
				begin
					other_errors++;
					$display("%s: write response arrived with none expected", test_name);
				end
				else
				begin
					exp_resp = resp_q.pop_front();
					check_resp(exp_resp, bresp);
				end
			end
			if (out_valid && out_ready)
			begin
				if (expect_q.size() == 0)
				begin
					other_errors++;
					$display("%s: bundle arrived with none expected", test_name);
				end
				else
				begin
					exp_bundle = expect_q.pop_front();
					check_bundle(exp_bundle, out_bundle);
				end
			end
		end
	end

	initial
	begin
		seed = 32'h4656;
		clk = 1'b0;
		rst = 1'b1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		out_ready = 1'b1;
		aw = '0;
		w = '0;
		mismatch_errors = 0;
		other_errors = 0;
		random_ready = 1'b0;
		test_name = "reset_latency";
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		check_flag("out_valid", 1'b0, out_valid);
		check_flag("awready", 1'b0, awready);
		check_flag("bvalid", 1'b0, bvalid);
		issue_instr({3'd0, 1'b0, 4'd1, 4'd2, 4'd3, 4'd1, 12'h005});
		while (!out_valid)
			@(posedge clk);
		check_latency(3, cycle_count - last_hs_cycle);
		drain();

		test_name = "group_decode";
		issue_instr({3'd0, 1'b0, 4'd1, 4'd2, 4'd3, 4'd3, 12'h7ff});
		issue_instr({3'd0, 1'b1, 4'd4, 4'd5, 4'd6, 4'd14, 12'h800});
		issue_instr({3'd1, 1'b0, 4'd7, 4'hc, 20'h80001});
		issue_instr({3'd1, 1'b1, 4'd8, 4'h5, 20'h12345});
		issue_instr({3'd2, 1'b0, 4'd9, 4'd10, 4'd11, 4'd8, 12'hf00});
		issue_instr({3'd2, 1'b1, 4'd1, 4'd1, 4'd1, 4'd12, 12'h001});
		issue_instr({3'd3, 1'b0, 4'd2, 4'd3, 4'd4, 4'd8, 12'h123});
		issue_instr({3'd3, 1'b0, 4'd2, 4'd3, 4'd4, 4'd12, 12'h923});
		issue_instr({3'd4, 1'b0, 4'd5, 4'd6, 4'd8, 16'h8000});
		issue_instr({3'd4, 1'b1, 4'd5, 4'd6, 4'd12, 16'h1234});
		issue_instr({3'd5, 29'h0abcdef});
		issue_instr({3'd6, 29'h1fffffff});
		issue_instr({3'd7, 29'h1234567});
		drain();

		// regs 12..15 still zero on the first pass
		test_name = "operand_read";
		for (int i = 0; i < 12; i++)
			write_bus(snow64_bus_pkg::ADDR_REG_BASE + {6'd0, 4'(i), 2'b00},
				32'h11110000 | 32'(i), 4'hf);
		for (int pass = 0; pass < 2; pass++)
		begin
			issue_instr({3'd0, 1'b0, 4'd12, 4'd3, 4'd15, 4'd0, 12'h000});
			issue_instr({3'd0, 1'b0, 4'd0, 4'd13, 4'd11, 4'd1, 12'h000});
			issue_instr({3'd2, 1'b0, 4'd14, 4'd7, 4'd5, 4'd2, 12'h010});
			if (pass == 0)
			begin
				for (int i = 12; i < 16; i++)
					write_bus(snow64_bus_pkg::ADDR_REG_BASE + {6'd0, 4'(i), 2'b00},
						32'h22220000 | 32'(i), 4'hf);
			end
		end
		drain();

		test_name = "write_order";
		for (int i = 0; i < 4; i++)
		begin
			write_bus(12'h054, 32'ha5000000 + 32'(i), 4'hf);
			issue_instr({3'd0, 1'b0, 4'd5, 4'd5, 4'd2, 4'd0, 12'h000});
		end
		drain();

		test_name = "bus_errors";
		write_bus(12'h100, 32'hdeadbeef, 4'hf);
		write_bus(12'h044, 32'h0bad0bad, 4'b0011);
		issue_instr({3'd0, 1'b0, 4'd1, 4'd1, 4'd1, 4'd0, 12'h000});
		drain();

		test_name = "random_stream";
		random_ready = 1'b1;
		for (int i = 0; i < 200; i++)
		begin
			stim_rnd = $random(seed);
			stim_data = $random(seed);
			if (stim_rnd[0])
				issue_instr(stim_data);
			else
				write_bus(snow64_bus_pkg::ADDR_REG_BASE + {6'd0, stim_rnd[4:1], 2'b00},
					stim_data, 4'hf);
		end
		random_ready = 1'b0;
		drain();

		if (expect_q.size() != 0)
		begin
			other_errors++;
			$display("%0d predicted bundles never arrived", expect_q.size());
		end
		if (resp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d write responses never arrived", resp_q.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
snow64_isa_pkg.sv
snow64_bus_pkg.sv
snow64_instr_ingress.sv
snow64_instr_decoder.sv
snow64_operand_fetch.sv
snow64_decode_front.sv
snow64_decode_front_tb.sv

// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing -j 0
TOP = snow64_decode_front_tb
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
